//--- carrierPkg.sv
`default_nettype none

package carrierPkg;

    // Datapath widths
    localparam int errorWidth = 8;
    localparam int dataWidth  = 32;
    localparam int addrWidth  = 12;
    localparam int expWidth   = 5;

    // Demodulation mode codes where code 7 is reserved and never feeds the loop
    localparam logic [2:0] modeAm    = 3'd0;
    localparam logic [2:0] modePm    = 3'd1;
    localparam logic [2:0] modeFm    = 3'd2;
    localparam logic [2:0] mode2Fsk  = 3'd3;
    localparam logic [2:0] modeBpsk  = 3'd4;
    localparam logic [2:0] modeQpsk  = 3'd5;
    localparam logic [2:0] modeOqpsk = 3'd6;

    // Constant removed from the scaled QPSK phase to center the error
    localparam logic [errorWidth-1:0] qpskBias = 8'h20;

    // The register space covers 0x100 to 0x1FF
    localparam logic [addrWidth-1:0] carrierBase      = 12'h100;
    localparam logic [addrWidth-1:0] carrierSpaceMask = 12'hF00;

    // Register offsets inside the space, taken from the low address byte
    localparam logic [7:0] regCtrl    = 8'h00;
    localparam logic [7:0] regLeadExp = 8'h04;
    localparam logic [7:0] regLagExp  = 8'h08;
    localparam logic [7:0] regLimit   = 8'h0C;

    // Bit positions in the control register
    localparam int ctrlInvertBit = 0;
    localparam int ctrlZeroBit   = 1;

    // Register stages from the sampling edge of sync to the output strobe
    localparam int loopLatency = 3;

endpackage

`default_nettype wire

//--- loopRegs.sv
`default_nettype none

module loopRegs (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [carrierPkg::addrWidth-1:0]    addr,
    input  logic [carrierPkg::dataWidth-1:0]    din,
    input  logic                                wr0,
    input  logic                                wr1,
    input  logic                                wr2,
    input  logic                                wr3,
    output logic [carrierPkg::dataWidth-1:0]    dout,
    output logic                                invertError,
    output logic                                zeroError,
    output logic [carrierPkg::expWidth-1:0]     leadExp,
    output logic [carrierPkg::expWidth-1:0]     lagExp,
    output logic [carrierPkg::dataWidth-1:0]    limit
);

    logic       inSpace;
    logic [7:0] offset;
    logic [1:0] ctrlReg;
    logic [3:0] byteWr;

    // Only the upper address bits take part in the space decode
    assign inSpace = (addr & carrierPkg::carrierSpaceMask) == carrierPkg::carrierBase;
    assign offset  = addr[7:0];
    assign byteWr  = {wr3, wr2, wr1, wr0};

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlReg <= '0;
            leadExp <= '0;
            lagExp  <= '0;
            limit   <= '0;
        end else if (inSpace) begin
            // The narrow registers live entirely in byte lane 0
            if (wr0 && offset == carrierPkg::regCtrl) begin
                ctrlReg <= din[1:0];
            end
            if (wr0 && offset == carrierPkg::regLeadExp) begin
                leadExp <= din[carrierPkg::expWidth-1:0];
            end
            if (wr0 && offset == carrierPkg::regLagExp) begin
                lagExp <= din[carrierPkg::expWidth-1:0];
            end
            if (offset == carrierPkg::regLimit) begin
                for (int i = 0; i < 4; i++) begin
                    if (byteWr[i]) begin
                        limit[8*i +: 8] <= din[8*i +: 8];
                    end
                end
            end
        end
    end

    assign invertError = ctrlReg[carrierPkg::ctrlInvertBit];
    assign zeroError   = ctrlReg[carrierPkg::ctrlZeroBit];

    // Readback is zero outside the space and at unmapped offsets
    always_comb begin
        dout = '0;
        if (inSpace) begin
            case (offset)
                carrierPkg::regCtrl:    dout = {30'd0, ctrlReg};
                carrierPkg::regLeadExp: dout = {27'd0, leadExp};
                carrierPkg::regLagExp:  dout = {27'd0, lagExp};
                carrierPkg::regLimit:   dout = limit;
                default:                dout = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- errorSource.sv
`default_nettype none

module errorSource (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                sync,
    input  logic [2:0]                          demodMode,
    input  logic [carrierPkg::errorWidth-1:0]   phase,
    input  logic [carrierPkg::errorWidth-1:0]   freq,
    input  logic [carrierPkg::errorWidth-1:0]   offsetError,
    input  logic                                offsetErrorEn,
    input  logic                                invertError,
    input  logic                                zeroError,
    output logic [carrierPkg::errorWidth-1:0]   loopError,
    output logic                                errorValid
);

    logic [carrierPkg::errorWidth-1:0] modeError;
    logic [carrierPkg::errorWidth-1:0] adjError;
    logic                              modeErrorEn;

    // Phase-type error for each demodulation mode
    always_comb begin
        modeError   = '0;
        modeErrorEn = 1'b1;
        case (demodMode)
            carrierPkg::modeAm: begin
                modeError = '0;
            end
            carrierPkg::modePm: begin
                modeError = phase;
            end
            carrierPkg::modeFm: begin
                modeError = freq;
            end
            carrierPkg::mode2Fsk: begin
                modeError   = offsetError;
                modeErrorEn = offsetErrorEn;
            end
            carrierPkg::modeBpsk: begin
                modeError = {phase[6:0], 1'b0};
            end
            carrierPkg::modeQpsk, carrierPkg::modeOqpsk: begin
                // Wraps modulo 256 by design
                modeError = {phase[5:0], 2'b00} - carrierPkg::qpskBias;
            end
            default: begin
                modeError   = '0;
                modeErrorEn = 1'b0;
            end
        endcase
    end

    // Zeroing wins over inversion
    always_comb begin
        if (zeroError) begin
            adjError = '0;
        end else if (invertError) begin
            adjError = ~modeError + 1'b1;
        end else begin
            adjError = modeError;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            errorValid <= 1'b0;
        end else begin
            errorValid <= sync & modeErrorEn;
        end
    end

    always_ff @(posedge clk) begin
        loopError <= adjError;
    end

endmodule

`default_nettype wire

//--- leadGain.sv
`default_nettype none

module leadGain (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [carrierPkg::errorWidth-1:0]   loopError,
    input  logic                                errorValid,
    input  logic [carrierPkg::expWidth-1:0]     leadExp,
    output logic [carrierPkg::dataWidth-1:0]    leadError,
    output logic                                leadValid
);

    localparam int extBits = carrierPkg::dataWidth - carrierPkg::errorWidth;

    logic [carrierPkg::dataWidth-1:0] errorExt;

    assign errorExt = {{extBits{loopError[carrierPkg::errorWidth-1]}}, loopError};

    // Power-of-two gain where bits shifted past the top are lost
    always_ff @(posedge clk) begin
        if (errorValid) begin
            leadError <= errorExt << leadExp;
        end
    end

    // Stage 2 valid shared with the lag path
    always_ff @(posedge clk) begin
        if (reset) begin
            leadValid <= 1'b0;
        end else begin
            leadValid <= errorValid;
        end
    end

endmodule

`default_nettype wire

//--- lagGain.sv
`default_nettype none

module lagGain (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [carrierPkg::errorWidth-1:0]   loopError,
    input  logic                                errorValid,
    input  logic [carrierPkg::expWidth-1:0]     lagExp,
    input  logic [carrierPkg::dataWidth-1:0]    limit,
    output logic [carrierPkg::dataWidth-1:0]    lagAccum
);

    localparam int extBits = carrierPkg::dataWidth - carrierPkg::errorWidth;

    logic [carrierPkg::dataWidth-1:0] errorExt;
    logic [carrierPkg::dataWidth-1:0] errorScaled;
    logic signed [carrierPkg::dataWidth:0] sum;
    logic signed [carrierPkg::dataWidth:0] posLimit;
    logic signed [carrierPkg::dataWidth:0] negLimit;
    logic [carrierPkg::dataWidth-1:0] nextAccum;

    assign errorExt    = {{extBits{loopError[carrierPkg::errorWidth-1]}}, loopError};
    assign errorScaled = errorExt << lagExp;

    // One extra bit keeps the sum from wrapping before the clamp
    assign sum = $signed({lagAccum[carrierPkg::dataWidth-1], lagAccum})
               + $signed({errorScaled[carrierPkg::dataWidth-1], errorScaled});

    // The limit register holds a magnitude, so both bounds come from it
    assign posLimit = $signed({1'b0, limit});
    assign negLimit = -posLimit;

    always_comb begin
        if (sum > posLimit) begin
            nextAccum = posLimit[carrierPkg::dataWidth-1:0];
        end else if (sum < negLimit) begin
            nextAccum = negLimit[carrierPkg::dataWidth-1:0];
        end else begin
            nextAccum = sum[carrierPkg::dataWidth-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lagAccum <= '0;
        end else if (errorValid) begin
            lagAccum <= nextAccum;
        end
    end

endmodule

`default_nettype wire

//--- carrierLoop.sv
`default_nettype none

module carrierLoop (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                sync,
    input  logic                                wr0,
    input  logic                                wr1,
    input  logic                                wr2,
    input  logic                                wr3,
    input  logic [carrierPkg::addrWidth-1:0]    addr,
    input  logic [carrierPkg::dataWidth-1:0]    din,
    input  logic [2:0]                          demodMode,
    input  logic [carrierPkg::errorWidth-1:0]   phase,
    input  logic [carrierPkg::errorWidth-1:0]   freq,
    input  logic [carrierPkg::errorWidth-1:0]   offsetError,
    input  logic                                offsetErrorEn,
    output logic [carrierPkg::dataWidth-1:0]    dout,
    output logic [carrierPkg::dataWidth-1:0]    carrierFreqOffset,
    output logic                                carrierFreqEn
);

    logic                               invertError;
    logic                               zeroError;
    logic [carrierPkg::expWidth-1:0]    leadExp;
    logic [carrierPkg::expWidth-1:0]    lagExp;
    logic [carrierPkg::dataWidth-1:0]   limit;
    logic [carrierPkg::errorWidth-1:0]  loopError;
    logic                               errorValid;
    logic [carrierPkg::dataWidth-1:0]   leadError;
    logic                               leadValid;
    logic [carrierPkg::dataWidth-1:0]   lagAccum;
    logic [carrierPkg::dataWidth-1:0]   filterSum;
    logic                               freqEnReg;

    loopRegs u_loopRegs (
        .clk         (clk),
        .reset       (reset),
        .addr        (addr),
        .din         (din),
        .wr0         (wr0),
        .wr1         (wr1),
        .wr2         (wr2),
        .wr3         (wr3),
        .dout        (dout),
        .invertError (invertError),
        .zeroError   (zeroError),
        .leadExp     (leadExp),
        .lagExp      (lagExp),
        .limit       (limit)
    );

    errorSource u_errorSource (
        .clk           (clk),
        .reset         (reset),
        .sync          (sync),
        .demodMode     (demodMode),
        .phase         (phase),
        .freq          (freq),
        .offsetError   (offsetError),
        .offsetErrorEn (offsetErrorEn),
        .invertError   (invertError),
        .zeroError     (zeroError),
        .loopError     (loopError),
        .errorValid    (errorValid)
    );

    leadGain u_leadGain (
        .clk        (clk),
        .reset      (reset),
        .loopError  (loopError),
        .errorValid (errorValid),
        .leadExp    (leadExp),
        .leadError  (leadError),
        .leadValid  (leadValid)
    );

    lagGain u_lagGain (
        .clk        (clk),
        .reset      (reset),
        .loopError  (loopError),
        .errorValid (errorValid),
        .lagExp     (lagExp),
        .limit      (limit),
        .lagAccum   (lagAccum)
    );

    // Third stage holds the filter output and its strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            filterSum <= '0;
            freqEnReg <= 1'b0;
        end else begin
            freqEnReg <= leadValid;
            if (leadValid) begin
                filterSum <= leadError + lagAccum;
            end
        end
    end

    assign carrierFreqOffset = filterSum;
    assign carrierFreqEn     = freqEnReg;

endmodule

`default_nettype wire

//--- tbClock.sv
`default_nettype none

module tbClock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int resetCycles = 16;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset drops on a falling edge like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- carrierLoop_props.sv
`default_nettype none

module carrierLoop_props (
    input logic       clk,
    input logic       reset,
    input logic       sync,
    input logic [2:0] demodMode,
    input logic       offsetErrorEn,
    input logic       carrierFreqEn
);
    timeunit 1ns;
    timeprecision 1ps;

    logic accepted;

    // A sample enters the loop only when its mode enable is high
    assign accepted = sync && ((demodMode == carrierPkg::mode2Fsk) ? offsetErrorEn
                                                                 : (demodMode != 3'd7));

    strobeLowInReset: assert property (@(posedge clk) reset |=> !carrierFreqEn)
        else $error("carrierFreqEn was high right after a reset cycle");

    strobeFollowsSample: assert property (@(posedge clk) disable iff (reset)
        carrierFreqEn |-> $past(accepted, carrierPkg::loopLatency))
        else $error("carrierFreqEn rose without an accepted sample three cycles before");

    strobeKnown: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(carrierFreqEn))
        else $error("carrierFreqEn is unknown");

endmodule

bind carrierLoop carrierLoop_props u_props (
    .clk           (clk),
    .reset         (reset),
    .sync          (sync),
    .demodMode     (demodMode),
    .offsetErrorEn (offsetErrorEn),
    .carrierFreqEn (carrierFreqEn)
);

`default_nettype wire

//--- carrierLoopTb.sv
`default_nettype none

module carrierLoopTb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [1:0]  ctrl;
        logic [4:0]  leadExp;
        logic [4:0]  lagExp;
        logic [31:0] limit;
        logic [2:0]  mode;
        logic [7:0]  count;
        logic [7:0]  syncPattern;
        logic        fixPhase;
        logic [7:0]  phaseValue;
    } stimRow;

    localparam logic [31:0] bigLimit = 32'h7FFF_FFFF;

    logic clk, reset, sync, wr0, wr1, wr2, wr3, offsetErrorEn, carrierFreqEn;
    logic [11:0] addr;
    logic [31:0] din, dout, carrierFreqOffset;
    logic [2:0] demodMode;
    logic [7:0] phase, freq, offsetError;

    stimRow rows[$];
    string names[$];
    string curName = "reset";
    logic [31:0] expQ[$];
    longint dueQ[$];
    longint cycle = 0;
    int strobeCount = 0;
    logic [31:0] lfsrState = 32'h0dd4_c179;

    // Model of the loop state
    longint modelAccum = 0;
    longint limitM = 0;
    logic invertM = 1'b0;
    logic zeroM = 1'b0;
    int leadExpM = 0;
    int lagExpM = 0;

    tbClock u_clock (.clk(clk), .reset(reset));

    carrierLoop u_dut (
        .clk(clk), .reset(reset), .sync(sync),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3), .addr(addr), .din(din),
        .demodMode(demodMode), .phase(phase), .freq(freq),
        .offsetError(offsetError), .offsetErrorEn(offsetErrorEn),
        .dout(dout), .carrierFreqOffset(carrierFreqOffset), .carrierFreqEn(carrierFreqEn)
    );

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic logic lfsrBit();
        logic out;
        out = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (out) lfsrState = lfsrState ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [7:0] randomByte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) b = {b[6:0], lfsrBit()};
        return b;
    endfunction

    function automatic logic [7:0] modeErrorOf(input logic [2:0] mode,
                                               input logic [7:0] ph, fr, oe);
        case (mode)
            carrierPkg::modePm:   return ph;
            carrierPkg::modeFm:   return fr;
            carrierPkg::mode2Fsk: return oe;
            carrierPkg::modeBpsk: return ph * 8'd2;
            carrierPkg::modeQpsk, carrierPkg::modeOqpsk: return ph * 8'd4 - carrierPkg::qpskBias;
            default:              return 8'h00;
        endcase
    endfunction

    function automatic logic modeEnabled(input logic [2:0] mode, input logic oeEn);
        if (mode == carrierPkg::mode2Fsk) return oeEn;
        return mode != 3'd7;
    endfunction

    // Lead plus saturated lag for one accepted error
    function automatic logic [31:0] modelStep(input logic [7:0] raw);
        logic [7:0] err;
        longint ext, lead, scaled, sum;
        err = zeroM ? 8'h00 : (invertM ? 8'h00 - raw : raw);
        ext = longint'($signed(err));
        lead = ext << leadExpM;
        scaled = longint'($signed(32'(ext << lagExpM)));
        sum = modelAccum + scaled;
        if (sum > limitM) sum = limitM;
        else if (sum < -limitM) sum = -limitM;
        modelAccum = sum;
        return 32'(lead) + 32'(sum);
    endfunction

    function automatic logic [11:0] regAddr(input logic [7:0] offset);
        return carrierPkg::carrierBase + {4'h0, offset};
    endfunction

    task automatic writeBus(input logic [11:0] a, input logic [31:0] d, input logic [3:0] wr);
        addr = a;
        din = d;
        {wr3, wr2, wr1, wr0} = wr;
        @(negedge clk);
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    task automatic checkRead(input logic [11:0] a, input logic [31:0] expected);
        addr = a;
        #1;
        assert (dout == expected) else failRun($sformatf(
            "MISMATCH %s read %h expected %h actual %h", curName, a, expected, dout));
        @(negedge clk);
    endtask

    task automatic waitReset();
        int guard = 0;
        // Reset is only looked at once the clock is running
        @(posedge clk);
        while (reset) begin
            @(negedge clk);
            guard++;
            assert (guard < 100) else failRun("Reset was never released");
        end
    endtask

    task automatic waitDrain();
        int guard = 0;
        while (expQ.size() > 0) begin
            @(negedge clk);
            guard++;
            assert (guard < 50) else failRun($sformatf(
                "Test %s stopped producing strobes with %0d values pending", curName, expQ.size()));
        end
        // Idle cycles let a stray strobe show up before the count is checked
        repeat (carrierPkg::loopLatency + 2) @(negedge clk);
    endtask

    task automatic regAccessTest();
        curName = "regAccess";
        writeBus(regAddr(carrierPkg::regCtrl), 32'hFFFF_FFFF, 4'b0001);
        checkRead(regAddr(carrierPkg::regCtrl), 32'h3);
        writeBus(regAddr(carrierPkg::regCtrl), 32'h0000_0000, 4'b1110);
        checkRead(regAddr(carrierPkg::regCtrl), 32'h3);
        writeBus(regAddr(carrierPkg::regLeadExp), 32'hFFFF_FFFF, 4'b1111);
        checkRead(regAddr(carrierPkg::regLeadExp), 32'h1F);
        writeBus(regAddr(carrierPkg::regLagExp), 32'h0000_0015, 4'b1111);
        checkRead(regAddr(carrierPkg::regLagExp), 32'h15);
        writeBus(regAddr(carrierPkg::regLimit), 32'h1122_3344, 4'b1111);
        checkRead(regAddr(carrierPkg::regLimit), 32'h1122_3344);
        writeBus(regAddr(carrierPkg::regLimit), 32'hAABB_CCDD, 4'b0101);
        checkRead(regAddr(carrierPkg::regLimit), 32'h11BB_33DD);
        writeBus(regAddr(carrierPkg::regLimit), 32'h9900_0000, 4'b1000);
        checkRead(regAddr(carrierPkg::regLimit), 32'h99BB_33DD);
        // Outside the space nothing is written and nothing reads back
        writeBus(12'h20C, 32'h0000_0000, 4'b1111);
        writeBus(12'h00C, 32'h0000_0000, 4'b1111);
        checkRead(regAddr(carrierPkg::regLimit), 32'h99BB_33DD);
        checkRead(12'h20C, 32'h0);
        checkRead(12'h00C, 32'h0);
        checkRead(regAddr(8'h10), 32'h0);
    endtask

    task automatic runRow(input int r);
        stimRow row;
        logic [7:0] raw;
        logic accept;
        int accepted = 0;
        row = rows[r];
        curName = names[r];
        strobeCount = 0;
        writeBus(regAddr(carrierPkg::regCtrl), {30'd0, row.ctrl}, 4'b1111);
        writeBus(regAddr(carrierPkg::regLeadExp), {27'd0, row.leadExp}, 4'b1111);
        writeBus(regAddr(carrierPkg::regLagExp), {27'd0, row.lagExp}, 4'b1111);
        writeBus(regAddr(carrierPkg::regLimit), row.limit, 4'b1111);
        checkRead(regAddr(carrierPkg::regLimit), row.limit);
        invertM = row.ctrl[0];
        zeroM = row.ctrl[1];
        leadExpM = row.leadExp;
        lagExpM = row.lagExp;
        limitM = row.limit;
        demodMode = row.mode;
        for (int i = 0; i < row.count; i++) begin
            phase = row.fixPhase ? row.phaseValue : randomByte();
            freq = randomByte();
            offsetError = randomByte();
            offsetErrorEn = lfsrBit();
            sync = row.syncPattern[i % 8];
            accept = sync && modeEnabled(row.mode, offsetErrorEn);
            if (accept) begin
                raw = modeErrorOf(row.mode, phase, freq, offsetError);
                expQ.push_back(modelStep(raw));
                dueQ.push_back(cycle + carrierPkg::loopLatency);
                accepted++;
            end
            @(negedge clk);
        end
        sync = 1'b0;
        waitDrain();
        assert (strobeCount == accepted) else failRun($sformatf(
            "MISMATCH %s strobe count expected %0d actual %0d", curName, accepted, strobeCount));
    endtask

    task automatic fillTable();
        // name, ctrl, leadExp, lagExp, limit, mode, count, sync pattern, fixed phase
        names.push_back("am");
        rows.push_back('{2'd0, 5'd0, 5'd0, bigLimit, carrierPkg::modeAm, 8'd24, 8'hFF, 1'b0, 8'h00});
        names.push_back("pm");
        rows.push_back('{2'd0, 5'd0, 5'd0, bigLimit, carrierPkg::modePm, 8'd24, 8'hFF, 1'b0, 8'h00});
        names.push_back("fm");
        rows.push_back('{2'd0, 5'd0, 5'd0, bigLimit, carrierPkg::modeFm, 8'd24, 8'hFF, 1'b0, 8'h00});
        names.push_back("fsk");
        rows.push_back('{2'd0, 5'd0, 5'd0, bigLimit, carrierPkg::mode2Fsk, 8'd40, 8'hFF, 1'b0, 8'h00});
        names.push_back("bpsk");
        rows.push_back('{2'd0, 5'd0, 5'd0, bigLimit, carrierPkg::modeBpsk, 8'd24, 8'hFF, 1'b0, 8'h00});
        names.push_back("qpsk");
        rows.push_back('{2'd0, 5'd0, 5'd0, bigLimit, carrierPkg::modeQpsk, 8'd48, 8'hFF, 1'b0, 8'h00});
        names.push_back("oqpsk");
        rows.push_back('{2'd0, 5'd0, 5'd0, bigLimit, carrierPkg::modeOqpsk, 8'd24, 8'hFF, 1'b0, 8'h00});
        names.push_back("reserved");
        rows.push_back('{2'd0, 5'd0, 5'd0, bigLimit, 3'd7, 8'd16, 8'hFF, 1'b0, 8'h00});
        names.push_back("syncGaps");
        rows.push_back('{2'd0, 5'd1, 5'd1, bigLimit, carrierPkg::modePm, 8'd40, 8'hB2, 1'b0, 8'h00});
        names.push_back("zero");
        rows.push_back('{2'd2, 5'd3, 5'd2, bigLimit, carrierPkg::modePm, 8'd24, 8'hFF, 1'b0, 8'h00});
        names.push_back("invert");
        rows.push_back('{2'd1, 5'd2, 5'd1, bigLimit, carrierPkg::modeFm, 8'd24, 8'hFF, 1'b0, 8'h00});
        names.push_back("satPos");
        rows.push_back('{2'd0, 5'd0, 5'd12, 32'd1000, carrierPkg::modePm, 8'd16, 8'hFF, 1'b1, 8'h30});
        names.push_back("satNeg");
        rows.push_back('{2'd0, 5'd0, 5'd12, 32'd1000, carrierPkg::modePm, 8'd16, 8'hFF, 1'b1, 8'hD0});
        names.push_back("pipeline");
        rows.push_back('{2'd0, 5'd4, 5'd3, bigLimit, carrierPkg::modePm, 8'd200, 8'hFF, 1'b0, 8'h00});
    endtask

    always @(posedge clk) cycle <= cycle + 1;

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin : monitor
        logic [31:0] expected;
        longint due;
        if (!reset && carrierFreqEn) begin
            strobeCount++;
            assert (expQ.size() > 0) else failRun($sformatf(
                "Test %s got a strobe with no accepted sample pending", curName));
            expected = expQ.pop_front();
            due = dueQ.pop_front();
            assert (carrierFreqOffset == expected) else failRun($sformatf(
                "MISMATCH %s offset expected %h actual %h", curName, expected, carrierFreqOffset));
            assert (cycle == due) else failRun($sformatf(
                "MISMATCH %s strobe cycle expected %0d actual %0d", curName, due, cycle));
        end
    end

    initial begin
        sync = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        addr = '0;
        din = '0;
        demodMode = '0;
        phase = '0;
        freq = '0;
        offsetError = '0;
        offsetErrorEn = 1'b0;
        fillTable();
        waitReset();
        regAccessTest();
        for (int r = 0; r < rows.size(); r++) runRow(r);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
carrierPkg.sv
loopRegs.sv
errorSource.sv
leadGain.sv
lagGain.sv
carrierLoop.sv
tbClock.sv
carrierLoop_props.sv
carrierLoopTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the result
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal -f compile.f \
        --top-module carrierLoopTb -o carrierLoopSim &&
    ./obj_dir/carrierLoopSim ||
    { echo "Simulation build or run failed" >&2; exit 1; }
